// ==== logic/rvc_pkg.sv ====
`default_nettype none

package rvc_pkg;

    // ------------------------------------------------------------------------
    // sizes and register map
    // ------------------------------------------------------------------------
    localparam int NUM_LANES = 2;
    localparam int PARCEL_W  = 16;
    localparam int INSTR_W   = 32;

    localparam int ADDR_W = 2;
    localparam logic [ADDR_W-1:0] REG_PARCELS = 2'd0;
    localparam logic [ADDR_W-1:0] REG_INSTR0  = 2'd1;
    localparam logic [ADDR_W-1:0] REG_INSTR1  = 2'd2;
    localparam logic [ADDR_W-1:0] REG_STATUS  = 2'd3;

    // lane k flags sit at 1+2k (compressed) and 2+2k (illegal)
    localparam int STAT_VALID = 0;

    // ------------------------------------------------------------------------
    // compressed encoding
    // ------------------------------------------------------------------------
    localparam logic [1:0] QUAD_C0   = 2'b00;
    localparam logic [1:0] QUAD_C1   = 2'b01;
    localparam logic [1:0] QUAD_C2   = 2'b10;
    localparam logic [1:0] QUAD_NONE = 2'b11;

    localparam logic [2:0] F3_C0_ADDI4SPN = 3'b000;
    localparam logic [2:0] F3_C0_LW       = 3'b010;
    localparam logic [2:0] F3_C0_SW       = 3'b110;

    localparam logic [2:0] F3_C1_ADDI = 3'b000;
    localparam logic [2:0] F3_C1_JAL  = 3'b001;
    localparam logic [2:0] F3_C1_LI   = 3'b010;
    localparam logic [2:0] F3_C1_LUI  = 3'b011;
    localparam logic [2:0] F3_C1_MISC = 3'b100;
    localparam logic [2:0] F3_C1_J    = 3'b101;
    localparam logic [2:0] F3_C1_BEQZ = 3'b110;
    localparam logic [2:0] F3_C1_BNEZ = 3'b111;

    localparam logic [2:0] F3_C2_SLLI  = 3'b000;
    localparam logic [2:0] F3_C2_LWSP  = 3'b010;
    localparam logic [2:0] F3_C2_JR_MV = 3'b100;
    localparam logic [2:0] F3_C2_SWSP  = 3'b110;

    // misc-alu select in parcel bits [11:10]
    localparam logic [1:0] MISC_SRLI  = 2'b00;
    localparam logic [1:0] MISC_SRAI  = 2'b01;
    localparam logic [1:0] MISC_ANDI  = 2'b10;
    localparam logic [1:0] MISC_ARITH = 2'b11;

    // register-register select in {bit 12, bits [6:5]}
    localparam logic [2:0] ARITH_SUB = 3'b000;
    localparam logic [2:0] ARITH_XOR = 3'b001;
    localparam logic [2:0] ARITH_OR  = 3'b010;
    localparam logic [2:0] ARITH_AND = 3'b011;

    // ------------------------------------------------------------------------
    // RV32I targets
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
    localparam logic [4:0]  REG_SP       = 5'd2;
    localparam logic [4:0]  REG_RA       = 5'd1;

    typedef union packed {
        // full register formats (CI, CR, CSS)
        struct packed {
            logic [2:0] funct3;
            logic       imm_hi;
            logic [4:0] rd;
            logic [4:0] imm_lo;
            logic [1:0] op;
        } ci;
        // three-bit register formats (CL, CS, CA, CB)
        struct packed {
            logic [2:0] funct3;
            logic [2:0] imm_hi;
            logic [2:0] rs1p;
            logic [1:0] imm_lo;
            logic [2:0] rdp;
            logic [1:0] op;
        } cl;
    } c_parcel_u;

endpackage

`default_nettype wire

// ==== logic/rvc_parcel_feed.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvc_parcel_feed (
    input  logic                                            clk_i,
    input  logic                                            reset_i,
    input  logic                                            wb_cyc_i,
    input  logic                                            wb_stb_i,
    input  logic                                            wb_we_i,
    input  logic [rvc_pkg::ADDR_W-1:0]                      wb_adr_i,
    input  logic [31:0]                                     wb_dat_i,
    output logic                                            wb_ack_o,
    output logic                                            load_o,
    output logic [rvc_pkg::ADDR_W-1:0]                      rd_sel_o,
    output logic [rvc_pkg::NUM_LANES*rvc_pkg::PARCEL_W-1:0] parcels_o
);

    logic accept;
    logic fetch_wr;

    // a request is taken once in the cycle before its ack
    assign accept   = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign fetch_wr = accept & wb_we_i & (wb_adr_i == rvc_pkg::REG_PARCELS);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
            load_o   <= 1'b0;
        end else begin
            wb_ack_o <= accept;
            load_o   <= fetch_wr;
        end
    end

    // address held for the drain's read mux
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rd_sel_o <= wb_adr_i;
        end
    end

    // low lane in the low half of the fetch word
    always_ff @(posedge clk_i) begin
        if (fetch_wr) begin
            parcels_o <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rvc_expander.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvc_expander (
    input  logic [rvc_pkg::PARCEL_W-1:0] parcel_i,
    output logic [rvc_pkg::INSTR_W-1:0]  instr_o,
    output logic                         compressed_o,
    output logic                         illegal_o
);

    rvc_pkg::c_parcel_u p;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    logic [11:0] imm6;
    logic [20:0] j_off;
    logic [12:0] b_off;
    logic [31:0] expanded;
    logic        bad;

    assign p    = parcel_i;
    assign rd   = p.ci.rd;
    assign rs2  = p.ci.imm_lo;
    // compact fields address x8..x15
    assign rdp  = {2'b01, p.cl.rdp};
    assign rs1p = {2'b01, p.cl.rs1p};
    assign imm6 = {{7{p.ci.imm_hi}}, p.ci.imm_lo};

    // jump and branch offsets with bit 0 always zero
    assign j_off = {{10{p[12]}}, p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
    assign b_off = {{5{p[12]}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};

    assign compressed_o = (p.ci.op != rvc_pkg::QUAD_NONE);

    // ------------------------------------------------------------------------
    // expansion by quadrant and funct3
    // ------------------------------------------------------------------------
    always_comb begin
        expanded = '0;
        bad      = 1'b0;
        case (p.ci.op)
            rvc_pkg::QUAD_C0: begin
                case (p.ci.funct3)
                    rvc_pkg::F3_C0_ADDI4SPN: begin
                        expanded = {2'b00, p[10:7], p[12:11], p[5], p[6], 2'b00, rvc_pkg::REG_SP,
                                    3'b000, rdp, rvc_pkg::OPC_OP_IMM};
                        bad      = (p[12:5] == 8'h00);
                    end
                    rvc_pkg::F3_C0_LW: begin
                        expanded = {5'b0, p.cl.imm_lo[0], p.cl.imm_hi, p.cl.imm_lo[1], 2'b00,
                                    rs1p, 3'b010, rdp, rvc_pkg::OPC_LOAD};
                    end
                    rvc_pkg::F3_C0_SW: begin
                        expanded = {5'b0, p[5], p[12], rdp, rs1p, 3'b010, p[11:10], p[6],
                                    2'b00, rvc_pkg::OPC_STORE};
                    end
                    // RV64 and floating-point slots land here
                    default: bad = 1'b1;
                endcase
            end

            rvc_pkg::QUAD_C1: begin
                case (p.ci.funct3)
                    rvc_pkg::F3_C1_ADDI: begin
                        expanded = {imm6, rd, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
                    end
                    rvc_pkg::F3_C1_JAL, rvc_pkg::F3_C1_J: begin
                        expanded = {j_off[20], j_off[10:1], j_off[11], j_off[19:12],
                                    (p.ci.funct3 == rvc_pkg::F3_C1_JAL) ? rvc_pkg::REG_RA : 5'd0,
                                    rvc_pkg::OPC_JAL};
                    end
                    rvc_pkg::F3_C1_LI: begin
                        expanded = {imm6, 5'd0, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
                    end
                    rvc_pkg::F3_C1_LUI: begin
                        if (rd == rvc_pkg::REG_SP) begin
                            // c.addi16sp
                            expanded = {{3{p[12]}}, p[4:3], p[5], p[2], p[6], 4'b0000,
                                        rvc_pkg::REG_SP, 3'b000, rvc_pkg::REG_SP,
                                        rvc_pkg::OPC_OP_IMM};
                        end else begin
                            expanded = {{15{p[12]}}, p[6:2], rd, rvc_pkg::OPC_LUI};
                        end
                        bad = ({p[12], p[6:2]} == 6'b0);
                    end
                    rvc_pkg::F3_C1_MISC: begin
                        case (p[11:10])
                            rvc_pkg::MISC_SRLI, rvc_pkg::MISC_SRAI: begin
                                expanded = {1'b0, p[10], 4'b0000, p[12], p[6:2], rs1p, 3'b101,
                                            rs1p, rvc_pkg::OPC_OP_IMM};
                            end
                            rvc_pkg::MISC_ANDI: begin
                                expanded = {imm6, rs1p, 3'b111, rs1p, rvc_pkg::OPC_OP_IMM};
                            end
                            default: begin
                                case ({p[12], p[6:5]})
                                    rvc_pkg::ARITH_SUB: begin
                                        expanded = {7'b0100000, rdp, rs1p, 3'b000, rs1p,
                                                    rvc_pkg::OPC_OP};
                                    end
                                    rvc_pkg::ARITH_XOR: begin
                                        expanded = {7'b0, rdp, rs1p, 3'b100, rs1p, rvc_pkg::OPC_OP};
                                    end
                                    rvc_pkg::ARITH_OR: begin
                                        expanded = {7'b0, rdp, rs1p, 3'b110, rs1p, rvc_pkg::OPC_OP};
                                    end
                                    rvc_pkg::ARITH_AND: begin
                                        expanded = {7'b0, rdp, rs1p, 3'b111, rs1p, rvc_pkg::OPC_OP};
                                    end
                                    // c.subw, c.addw and reserved
                                    default: bad = 1'b1;
                                endcase
                            end
                        endcase
                    end
                    // c.beqz and c.bnez where bit 13 picks bne
                    default: begin
                        expanded = {b_off[12], b_off[10:5], 5'd0, rs1p, 2'b00, p[13], b_off[4:1],
                                    b_off[11], rvc_pkg::OPC_BRANCH};
                    end
                endcase
            end

            rvc_pkg::QUAD_C2: begin
                case (p.ci.funct3)
                    rvc_pkg::F3_C2_SLLI: begin
                        expanded = {6'b0, p[12], p[6:2], rd, 3'b001, rd, rvc_pkg::OPC_OP_IMM};
                    end
                    rvc_pkg::F3_C2_LWSP: begin
                        expanded = {4'b0, p[3:2], p[12], p[6:4], 2'b00, rvc_pkg::REG_SP, 3'b010,
                                    rd, rvc_pkg::OPC_LOAD};
                        bad      = (rd == 5'd0);
                    end
                    rvc_pkg::F3_C2_JR_MV: begin
                        if (!p[12]) begin
                            if (rs2 == 5'd0) begin
                                // c.jr
                                expanded = {12'h000, rd, 3'b000, 5'd0, rvc_pkg::OPC_JALR};
                                bad      = (rd == 5'd0);
                            end else begin
                                expanded = {7'b0, rs2, 5'd0, 3'b000, rd, rvc_pkg::OPC_OP};
                            end
                        end else if (rs2 == 5'd0 && rd == 5'd0) begin
                            expanded = rvc_pkg::INSTR_EBREAK;
                        end else if (rs2 == 5'd0) begin
                            expanded = {12'h000, rd, 3'b000, rvc_pkg::REG_RA, rvc_pkg::OPC_JALR};
                        end else begin
                            expanded = {7'b0, rs2, rd, 3'b000, rd, rvc_pkg::OPC_OP};
                        end
                    end
                    rvc_pkg::F3_C2_SWSP: begin
                        expanded = {4'b0, p[8:7], p[12], rs2, rvc_pkg::REG_SP, 3'b010, p[11:9],
                                    2'b00, rvc_pkg::OPC_STORE};
                    end
                    default: bad = 1'b1;
                endcase
            end

            default: expanded = '0;
        endcase
    end

    assign illegal_o = bad;
    // illegal and full-width parcels pass through zero-extended
    assign instr_o   = (bad || !compressed_o) ?
                       {{(rvc_pkg::INSTR_W-rvc_pkg::PARCEL_W){1'b0}}, parcel_i} : expanded;

endmodule

`default_nettype wire

// ==== logic/rvc_result_drain.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvc_result_drain (
    input  logic                                           clk_i,
    input  logic                                           reset_i,
    input  logic                                           load_i,
    input  logic [rvc_pkg::ADDR_W-1:0]                     rd_sel_i,
    input  logic [rvc_pkg::NUM_LANES*rvc_pkg::INSTR_W-1:0] lane_instr_i,
    input  logic [rvc_pkg::NUM_LANES-1:0]                  lane_compressed_i,
    input  logic [rvc_pkg::NUM_LANES-1:0]                  lane_illegal_i,
    output logic [31:0]                                    wb_dat_o
);

    logic [rvc_pkg::NUM_LANES*rvc_pkg::INSTR_W-1:0] instr_q;
    logic [rvc_pkg::NUM_LANES-1:0]                  compressed_q;
    logic [rvc_pkg::NUM_LANES-1:0]                  illegal_q;
    logic                                           valid_q;
    logic [31:0]                                    status;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_q      <= '0;
            compressed_q <= '0;
            illegal_q    <= '0;
            valid_q      <= 1'b0;
        end else if (load_i) begin
            instr_q      <= lane_instr_i;
            compressed_q <= lane_compressed_i;
            illegal_q    <= lane_illegal_i;
            valid_q      <= 1'b1;
        end
    end

    // valid in bit 0, then a compressed/illegal pair per lane
    always_comb begin
        status                      = '0;
        status[rvc_pkg::STAT_VALID] = valid_q;
        for (int k = 0; k < rvc_pkg::NUM_LANES; k++) begin
            status[1+2*k] = compressed_q[k];
            status[2+2*k] = illegal_q[k];
        end
    end

    always_comb begin
        case (rd_sel_i)
            rvc_pkg::REG_INSTR0: wb_dat_o = instr_q[0 +: rvc_pkg::INSTR_W];
            rvc_pkg::REG_INSTR1: wb_dat_o = instr_q[rvc_pkg::INSTR_W +: rvc_pkg::INSTR_W];
            rvc_pkg::REG_STATUS: wb_dat_o = status;
            // fetch register is write only
            default:             wb_dat_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/rvc_decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvc_decode_top (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [rvc_pkg::ADDR_W-1:0]   wb_adr_i,
    input  logic [31:0]                  wb_dat_i,
    output logic                         wb_ack_o,
    output logic [31:0]                  wb_dat_o
);

    logic                                            load;
    logic [rvc_pkg::ADDR_W-1:0]                      rd_sel;
    logic [rvc_pkg::NUM_LANES*rvc_pkg::PARCEL_W-1:0] parcels;
    logic [rvc_pkg::NUM_LANES*rvc_pkg::INSTR_W-1:0]  lane_instr;
    logic [rvc_pkg::NUM_LANES-1:0]                   lane_compressed;
    logic [rvc_pkg::NUM_LANES-1:0]                   lane_illegal;

    rvc_parcel_feed i_parcel_feed (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_ack_o  (wb_ack_o),
        .load_o    (load),
        .rd_sel_o  (rd_sel),
        .parcels_o (parcels)
    );

    // one decode lane per parcel of the fetch word
    for (genvar k = 0; k < rvc_pkg::NUM_LANES; k++) begin : g_lane
        rvc_expander i_expander (
            .parcel_i     (parcels[k*rvc_pkg::PARCEL_W +: rvc_pkg::PARCEL_W]),
            .instr_o      (lane_instr[k*rvc_pkg::INSTR_W +: rvc_pkg::INSTR_W]),
            .compressed_o (lane_compressed[k]),
            .illegal_o    (lane_illegal[k])
        );
    end

    rvc_result_drain i_result_drain (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .load_i            (load),
        .rd_sel_i          (rd_sel),
        .lane_instr_i      (lane_instr),
        .lane_compressed_i (lane_compressed),
        .lane_illegal_i    (lane_illegal),
        .wb_dat_o          (wb_dat_o)
    );

endmodule

`default_nettype wire

// ==== dv/rvc_decode_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvc_decode_assert (
    input logic                          clk_i,
    input logic                          reset_i,
    input logic                          wb_cyc_i,
    input logic                          wb_stb_i,
    input logic                          wb_ack_i,
    input logic [rvc_pkg::NUM_LANES-1:0] lane_compressed_i,
    input logic [rvc_pkg::NUM_LANES-1:0] lane_illegal_i
);

    // ack follows a request seen one cycle earlier
    ack_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(wb_ack_i) |-> $past(wb_cyc_i && wb_stb_i))
        else $error("ack raised without a request");

    ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_ack_i |=> !wb_ack_i)
        else $error("ack held for two cycles");

    illegal_is_compressed: assert property (@(posedge clk_i) disable iff (reset_i)
        (|lane_illegal_i) |-> ((lane_illegal_i & ~lane_compressed_i) == '0))
        else $error("illegal flag on a full-width parcel");

endmodule

bind rvc_decode_top rvc_decode_assert i_rvc_decode_assert (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_ack_i          (wb_ack_o),
    .lane_compressed_i (lane_compressed),
    .lane_illegal_i    (lane_illegal)
);

`default_nettype wire

// ==== include/rvc_model.svh ====
`ifndef RVC_MODEL_SVH
`define RVC_MODEL_SVH

// RV32I field packers for the reference expansion
function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvc_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rvc_pkg::OPC_OP};
endfunction

// expected word and flags of one parcel
function automatic void expand_parcel(input logic [15:0] c, output logic [31:0] instr,
                                      output logic comp, output logic ill);
    rvc_pkg::c_parcel_u u;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    logic [11:0] simm;
    logic [20:0] joff;
    logic [12:0] boff;
    logic [2:0]  f3;
    u     = c;
    rd    = u.ci.rd;
    rs2   = u.ci.imm_lo;
    rdp   = {2'b01, u.cl.rdp};
    rs1p  = {2'b01, u.cl.rs1p};
    simm  = {{7{c[12]}}, c[6:2]};
    joff  = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    boff  = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    comp  = (c[1:0] != 2'b11);
    ill   = 1'b0;
    instr = 32'h0;
    case ({c[1:0], c[15:13]})
        5'b00_000: begin
            instr = itype_word({2'b0, c[10:7], c[12:11], c[5], c[6], 2'b0}, 5'd2, 3'b000, rdp,
                               rvc_pkg::OPC_OP_IMM);
            ill   = (c[12:5] == 8'h00);
        end
        5'b00_010: begin
            instr = itype_word({5'b0, c[5], c[12:10], c[6], 2'b0}, rs1p, 3'b010, rdp,
                               rvc_pkg::OPC_LOAD);
        end
        5'b00_110: instr = stype_word({5'b0, c[5], c[12:10], c[6], 2'b0}, rdp, rs1p);
        5'b01_000: instr = itype_word(simm, rd, 3'b000, rd, rvc_pkg::OPC_OP_IMM);
        5'b01_001: instr = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd1, rvc_pkg::OPC_JAL};
        5'b01_010: instr = itype_word(simm, 5'd0, 3'b000, rd, rvc_pkg::OPC_OP_IMM);
        5'b01_011: begin
            ill = ({c[12], c[6:2]} == 6'b0);
            if (rd == 5'd2) begin
                instr = itype_word({{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0}, 5'd2, 3'b000,
                                   5'd2, rvc_pkg::OPC_OP_IMM);
            end else begin
                instr = {{15{c[12]}}, c[6:2], rd, rvc_pkg::OPC_LUI};
            end
        end
        5'b01_100: begin
            case (c[11:10])
                2'b00: instr = itype_word({6'b000000, c[12], c[6:2]}, rs1p, 3'b101, rs1p,
                                          rvc_pkg::OPC_OP_IMM);
                2'b01: instr = itype_word({6'b010000, c[12], c[6:2]}, rs1p, 3'b101, rs1p,
                                          rvc_pkg::OPC_OP_IMM);
                2'b10: instr = itype_word(simm, rs1p, 3'b111, rs1p, rvc_pkg::OPC_OP_IMM);
                default: begin
                    ill = c[12];
                    // sub, xor, or, and
                    case (c[6:5])
                        2'b00:   f3 = 3'b000;
                        2'b01:   f3 = 3'b100;
                        2'b10:   f3 = 3'b110;
                        default: f3 = 3'b111;
                    endcase
                    instr = rtype_word((c[6:5] == 2'b00) ? 7'b0100000 : 7'b0, rdp, rs1p, f3,
                                       rs1p);
                end
            endcase
        end
        5'b01_101: instr = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, rvc_pkg::OPC_JAL};
        5'b01_110, 5'b01_111: begin
            instr = {boff[12], boff[10:5], 5'd0, rs1p, 2'b00, c[13], boff[4:1], boff[11],
                     rvc_pkg::OPC_BRANCH};
        end
        5'b10_000: instr = itype_word({6'b0, c[12], c[6:2]}, rd, 3'b001, rd, rvc_pkg::OPC_OP_IMM);
        5'b10_010: begin
            instr = itype_word({4'b0, c[3:2], c[12], c[6:4], 2'b0}, 5'd2, 3'b010, rd,
                               rvc_pkg::OPC_LOAD);
            ill   = (rd == 5'd0);
        end
        5'b10_100: begin
            if (rs2 != 5'd0) begin
                instr = rtype_word(7'b0, rs2, c[12] ? rd : 5'd0, 3'b000, rd);
            end else if (c[12] && rd == 5'd0) begin
                instr = rvc_pkg::INSTR_EBREAK;
            end else begin
                instr = itype_word(12'h000, rd, 3'b000, c[12] ? 5'd1 : 5'd0, rvc_pkg::OPC_JALR);
                ill   = !c[12] && (rd == 5'd0);
            end
        end
        5'b10_110: instr = stype_word({4'b0, c[8:7], c[12:9], 2'b0}, rs2, 5'd2);
        default:   ill = comp;
    endcase
    if (ill || !comp) begin
        instr = {16'h0000, c};
    end
endfunction

`endif

// ==== dv/tb_rvc_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rvc_decode;

    logic                       clk_i;
    logic                       reset_i;
    logic                       wb_cyc_i;
    logic                       wb_stb_i;
    logic                       wb_we_i;
    logic [rvc_pkg::ADDR_W-1:0] wb_adr_i;
    logic [31:0]                wb_dat_i;
    logic                       wb_ack_o;
    logic [31:0]                wb_dat_o;
    logic [31:0]                rng;

    `include "rvc_model.svh"

    rvc_decode_top i_rvc_decode_top (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o)
    );

    always #10 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic random_parcel(output logic [15:0] p);
        rng = xorshift(rng);
        p   = rng[15:0];
        // roughly one in eight stays a full-width parcel
        if (rng[31:29] == 3'b000) begin
            p[1:0] = 2'b11;
        end else begin
            p[1:0] = (rng[28:27] == 2'b11) ? {1'b0, rng[26]} : rng[28:27];
        end
    endtask

    // ------------------------------------------------------------------------
    // Wishbone master
    // ------------------------------------------------------------------------
    task automatic wait_ack();
        int n;
        n = 0;
        @(posedge clk_i);
        while (wb_ack_o !== 1'b1) begin
            n++;
            if (n > 16) begin
                $display("bus did not acknowledge within 16 cycles at %0t", $time);
                $display("Done: errors found");
                $fatal(1, "bus timeout");
            end
            @(posedge clk_i);
        end
    endtask

    task automatic bus_write(input logic [rvc_pkg::ADDR_W-1:0] adr, input logic [31:0] dat);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wait_ack();
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic bus_read(input logic [rvc_pkg::ADDR_W-1:0] adr, output logic [31:0] dat);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b0;
        wb_adr_i <= adr;
        wait_ack();
        dat = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_instr(input string what, input logic [rvc_pkg::INSTR_W-1:0] act,
                               input logic [rvc_pkg::INSTR_W-1:0] exp);
        if (act !== exp) begin
            $display("ERR %0t %s expected %08h got %08h", $time, what, exp, act);
            $display("Done: errors found");
            $fatal(1, "instruction mismatch");
        end
    endtask

    task automatic check_status(input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("ERR %0t status expected %08h got %08h", $time, exp, act);
            $display("Done: errors found");
            $fatal(1, "status mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequences
    // ------------------------------------------------------------------------
    task automatic check_results(input logic [31:0] word);
        logic [31:0] exp0;
        logic [31:0] exp1;
        logic [31:0] act;
        logic        c0;
        logic        i0;
        logic        c1;
        logic        i1;
        expand_parcel(word[15:0], exp0, c0, i0);
        expand_parcel(word[31:16], exp1, c1, i1);
        bus_read(rvc_pkg::REG_INSTR0, act);
        check_instr("instr0", act, exp0);
        bus_read(rvc_pkg::REG_INSTR1, act);
        check_instr("instr1", act, exp1);
        bus_read(rvc_pkg::REG_STATUS, act);
        check_status(act, {27'b0, i1, c1, i0, c0, 1'b1});
    endtask

    task automatic run_word(input logic [31:0] word);
        bus_write(rvc_pkg::REG_PARCELS, word);
        check_results(word);
    endtask

    // lane 0 carries the parcel, lane 1 a c.nop
    task automatic check_passthru(input logic [15:0] parcel, input logic comp, input logic ill);
        logic [31:0] act;
        bus_write(rvc_pkg::REG_PARCELS, {16'h0001, parcel});
        bus_read(rvc_pkg::REG_INSTR0, act);
        check_instr("zero-extended parcel", act, {16'h0000, parcel});
        bus_read(rvc_pkg::REG_STATUS, act);
        check_status(act, {27'b0, 1'b0, 1'b1, ill, comp, 1'b1});
    endtask

    initial begin
        logic [15:0] lo;
        logic [15:0] hi;
        logic [31:0] act;
        int          n;

        clk_i    = 1'b0;
        reset_i  = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        rng      = 32'hbb3d;
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;

        // nothing loaded yet
        bus_read(rvc_pkg::REG_STATUS, act);
        check_status(act, 32'h0);

        for (n = 0; n < 400; n++) begin
            random_parcel(lo);
            random_parcel(hi);
            run_word({hi, lo});
        end

        // addi4spn, lwsp, jr, lui, then c.flw
        check_passthru(16'h0004, 1'b1, 1'b1);
        check_passthru(16'h4012, 1'b1, 1'b1);
        check_passthru(16'h8002, 1'b1, 1'b1);
        check_passthru(16'h6281, 1'b1, 1'b1);
        check_passthru(16'h6008, 1'b1, 1'b1);
        check_passthru(16'h4a2f, 1'b0, 1'b0);

        // ebreak/nop, jal/addi16sp, bnez/beqz, jr/mv
        run_word({16'h9002, 16'h0001});
        run_word({16'h3fed, 16'h7101});
        run_word({16'hfd59, 16'hdc7d});
        run_word({16'h8082, 16'h852e});

        // result registers are read only
        bus_write(rvc_pkg::REG_INSTR0, 32'hdead_beef);
        check_results({16'h8082, 16'h852e});
        bus_read(rvc_pkg::REG_PARCELS, act);
        check_instr("fetch register read", act, 32'h0);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
logic/rvc_pkg.sv
logic/rvc_parcel_feed.sv
logic/rvc_expander.sv
logic/rvc_result_drain.sv
logic/rvc_decode_top.sv
dv/rvc_decode_assert.sv
dv/tb_rvc_decode.sv

// ==== Makefile ====
TOP := tb_rvc_decode

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
